//--- acl_report.f
+incdir+include
+incdir+verif
verilog/acl_report_pkg.sv
verilog/adxl362_readings_to_ascii.sv
verilog/uart_tx_feed.sv
verilog/uart_tx_serializer.sv
verilog/acl_report_top.sv
verif/tb_acl_report.sv

//--- verif/tb_acl_report_ref.svh
`ifndef TB_ACL_REPORT_REF_SVH
`define TB_ACL_REPORT_REF_SVH

// Expected terminal line for one report, first character in the top byte
function automatic uart_line_t expected_line(input acl_meas_t meas,
                                             input logic inactive,
                                             input logic [3:0] btn);
  logic [127:0] hex_tab;   // Digit glyphs indexed by nibble value
  logic [127:0] row1;
  logic [127:0] row2;
  logic [31:0]  names;     // Field letters in send order
  logic [7:0]   chars [0:33];
  uart_line_t   line;
  acl_axis_t    field;
  int           nib;
  int           i;
  int           f;
  int           d;
  hex_tab = "0123456789ABCDEF";
  names   = "XYZT";
  if (btn == `ACL_BTN_TEXT_SEL) begin
    row1 = "ACL2 READINGS   ";
    row2 = inactive ? "STATE: INACTIVE " : "STATE: ACTIVE   ";
    for (i = 0; i < 16; i++) begin
      chars[i]      = row1[127-8*i -: 8];
      chars[16 + i] = row2[127-8*i -: 8];
    end
  end else begin
    // Four fields of eight characters, "L=hhhh  "
    for (f = 0; f < 4; f++) begin
      field          = meas[63-16*f -: 16];
      chars[8*f]     = names[31-8*f -: 8];
      chars[8*f + 1] = 8'h3D;  // '='
      for (d = 0; d < 4; d++) begin
        nib                = int'(field[15-4*d -: 4]);
        chars[8*f + 2 + d] = hex_tab[127-8*nib -: 8];
      end
      chars[8*f + 6] = 8'h20;
      chars[8*f + 7] = 8'h20;
    end
  end
  chars[32] = 8'h0D;  // CR
  chars[33] = 8'h0A;  // LF
  for (i = 0; i < 34; i++) begin
    line[271-8*i -: 8] = chars[i];
  end
  return line;
endfunction

`endif

//--- verif/tb_acl_report.sv
`timescale 1ns/1ps
`include "acl_report_params.svh"

module tb_acl_report
  import acl_report_pkg::*;
();

  `include "tb_acl_report_ref.svh"

  // ------------------------------------------------------------------------
  // Run length
  // ------------------------------------------------------------------------

  localparam int c_half_bit      = `ACL_CLKS_PER_BIT / 2;
  localparam int c_report_cycles = `ACL_UART_CHARS * 10 * `ACL_CLKS_PER_BIT;
  localparam int c_num_reports   = 7;
  localparam int c_max_cycles    = c_num_reports * c_report_cycles + 20000;  // Plus margin

  logic        s_clk_20mhz;
  logic        s_rst_20mhz;
  acl_meas_t   s_meas;
  logic        s_meas_valid;
  logic        s_reading_inactive;
  logic [3:0]  s_btn_deb;
  logic        s_report_go;
  logic        s_uart_tx;
  logic        s_report_busy;

  ascii_char_t rx_q[$];       // Characters off the wire
  ascii_char_t exp_q[$];      // Characters still expected
  int          frames_rx;     // Frames in the current report
  int          cycle_cnt = 0;
  acl_meas_t   model_hold;    // Reading the DUT should hold

  acl_report_top acl_report_top_inst (
    .s_clk_20mhz       (s_clk_20mhz),
    .s_rst_20mhz       (s_rst_20mhz),
    .i_meas            (s_meas),
    .i_meas_valid      (s_meas_valid),
    .i_reading_inactive(s_reading_inactive),
    .i_btn_deb         (s_btn_deb),
    .i_report_go       (s_report_go),
    .o_uart_tx         (s_uart_tx),
    .o_report_busy     (s_report_busy)
  );

  initial begin : p_clock
    s_clk_20mhz = 1'b0;
    forever #25 s_clk_20mhz = ~s_clk_20mhz;  // 20 MHz
  end : p_clock

  // ------------------------------------------------------------------------
  // Error handling and checks
  // ------------------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic compare_values(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  always @(posedge s_clk_20mhz) begin : p_timeout
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= c_max_cycles) begin
      abort_run($sformatf("Timeout: run not finished after %0d cycles", cycle_cnt));
    end
  end : p_timeout

  // ------------------------------------------------------------------------
  // UART receiver sampling at bit centres
  // ------------------------------------------------------------------------

  initial begin : p_uart_rx
    ascii_char_t data;
    int          idle;
    int          b;
    idle = 0;
    @(negedge s_rst_20mhz);
    forever begin
      @(negedge s_clk_20mhz);
      if (s_uart_tx === 1'b0) begin
        idle = 0;
        repeat (c_half_bit) @(negedge s_clk_20mhz);
        if (s_uart_tx !== 1'b0) begin
          abort_run("Start bit went high before its centre");
        end else begin
          for (b = 0; b < 8; b++) begin
            repeat (`ACL_CLKS_PER_BIT) @(negedge s_clk_20mhz);
            data[b] = s_uart_tx;  // LSB first
          end
          repeat (`ACL_CLKS_PER_BIT) @(negedge s_clk_20mhz);
          if (s_uart_tx !== 1'b1) begin
            abort_run("Bad stop bit: line low at the stop bit centre");
          end else begin
            rx_q.push_back(data);
            frames_rx++;
          end
        end
      end else if (s_report_busy && frames_rx > 0 && frames_rx < `ACL_UART_CHARS) begin
        idle++;
        // Rest of stop bit plus the largest allowed gap
        if (idle > c_half_bit + 6) begin
          abort_run("Missing start bit: next frame did not follow within the gap");
        end
      end
    end
  end : p_uart_rx

  initial begin : p_compare
    ascii_char_t got;
    int          idx;
    idx = 0;
    forever begin
      @(posedge s_clk_20mhz);
      if (rx_q.size() > 0) begin
        got = rx_q.pop_front();
        if (exp_q.size() == 0) begin
          abort_run("A frame arrived while no report was expected");
        end else begin
          compare_values($sformatf("o_uart_tx char %0d", idx), got, exp_q.pop_front());
          idx = (idx + 1) % `ACL_UART_CHARS;
        end
      end
    end
  end : p_compare

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------

  task automatic drive_reading(input acl_meas_t meas, input bit taken);
    @(negedge s_clk_20mhz);
    s_meas       = meas;
    s_meas_valid = 1'b1;
    @(negedge s_clk_20mhz);
    s_meas_valid = 1'b0;
    if (taken) begin
      model_hold = meas;
    end
  endtask

  // One report with an optional reading and second strobe mid-report
  task automatic run_report(input logic [3:0] btn, input logic inactive, input bit disturb);
    uart_line_t exp_line;
    int         i;
    int         wait_cnt;
    @(negedge s_clk_20mhz);
    s_btn_deb          = btn;
    s_reading_inactive = inactive;
    repeat (3) @(negedge s_clk_20mhz);  // Let the line register settle
    exp_line = expected_line(model_hold, inactive, btn);
    for (i = 0; i < `ACL_UART_CHARS; i++) begin
      exp_q.push_back(exp_line[271-8*i -: 8]);
    end
    frames_rx   = 0;
    s_report_go = 1'b1;
    @(negedge s_clk_20mhz);
    s_report_go = 1'b0;
    compare_values("o_report_busy", s_report_busy, 1);
    wait_cnt = 0;
    while (s_uart_tx !== 1'b0 && wait_cnt < 4) begin
      @(negedge s_clk_20mhz);
      wait_cnt++;
    end
    if (s_uart_tx !== 1'b0) begin
      abort_run("Missing start bit: first frame not begun within 4 cycles of the strobe");
    end
    if (disturb) begin
      repeat (c_report_cycles / 3) @(negedge s_clk_20mhz);
      drive_reading({$urandom, $urandom}, 1'b0);  // Must not be captured
      s_report_go = 1'b1;  // Ignored while busy
      @(negedge s_clk_20mhz);
      s_report_go = 1'b0;
    end
    while (s_report_busy === 1'b1) @(negedge s_clk_20mhz);
    compare_values("frames per report", frames_rx, `ACL_UART_CHARS);
    repeat (2 * `ACL_CLKS_PER_BIT) begin
      @(negedge s_clk_20mhz);
      compare_values("o_report_busy", s_report_busy, 0);
      compare_values("o_uart_tx", s_uart_tx, 1);
    end
    compare_values("characters left unchecked", exp_q.size(), 0);
  endtask

  initial begin : p_main
    acl_meas_t meas;
    int        i;
    void'($urandom(32'hdf14));
    s_rst_20mhz        = 1'b1;
    s_meas             = '0;
    s_meas_valid       = 1'b0;
    s_reading_inactive = 1'b0;
    s_btn_deb          = 4'b0000;
    s_report_go        = 1'b0;
    model_hold         = '0;
    frames_rx          = 0;
    repeat (16) @(posedge s_clk_20mhz);
    @(negedge s_clk_20mhz);
    s_rst_20mhz = 1'b0;

    // Quiet line after reset
    repeat (200) begin
      @(negedge s_clk_20mhz);
      compare_values("o_uart_tx", s_uart_tx, 1);
      compare_values("o_report_busy", s_report_busy, 0);
    end

    // Data view with a reading and a strobe thrown in while busy
    meas = {$urandom, $urandom};
    drive_reading(meas, 1'b1);
    run_report(4'b0000, 1'b0, 1'b1);
    run_report(4'b0000, 1'b0, 1'b0);  // Still the first reading

    // Text view with the flag low then high
    run_report(`ACL_BTN_TEXT_SEL, 1'b0, 1'b0);
    run_report(`ACL_BTN_TEXT_SEL, 1'b1, 1'b0);

    // Back-to-back reports with fresh readings
    for (i = 0; i < 3; i++) begin
      meas = {$urandom, $urandom};
      drive_reading(meas, 1'b1);
      run_report({i[1:0], 2'b01}, i[0], 1'b0);
    end

    repeat (4) @(negedge s_clk_20mhz);
    if (rx_q.size() == 0 && exp_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "Characters left over at the end of the run");
    end
  end : p_main

endmodule : tb_acl_report

//--- verilog/acl_report_top.sv
`timescale 1ns/1ps

module acl_report_top
  import acl_report_pkg::*;
(
  input  logic      s_clk_20mhz,
  input  logic      s_rst_20mhz,
  input  acl_meas_t i_meas,              // Packed X, Y, Z, temperature
  input  logic      i_meas_valid,        // Single-cycle strobe
  input  logic      i_reading_inactive,  // Inactivity flag from tester
  input  logic [3:0] i_btn_deb,          // Debounced button levels
  input  logic      i_report_go,         // Start of one terminal report
  output logic      o_uart_tx,
  output logic      o_report_busy
);

  // ------------------------------------------------------------------------
  // Internal connections
  // ------------------------------------------------------------------------

  uart_line_t  s_uart_line;   // Registered 34-character terminal line
  logic        s_feed_idle;   // Feed ready for another report
  ascii_char_t s_tx_data;     // Byte from feed to serializer
  logic        s_tx_valid;
  logic        s_tx_ready;

  assign o_report_busy = ~s_feed_idle;

  // Reading hold and ASCII formatting
  adxl362_readings_to_ascii u_readings_to_ascii (
    .s_clk_20mhz       (s_clk_20mhz),
    .s_rst_20mhz       (s_rst_20mhz),
    .i_meas            (i_meas),
    .i_meas_valid      (i_meas_valid),
    .i_feed_idle       (s_feed_idle),
    .i_reading_inactive(i_reading_inactive),
    .i_btn_deb         (i_btn_deb),
    .o_uart_line       (s_uart_line)
  );

  // Line latch and byte sequencing
  uart_tx_feed u_uart_tx_feed (
    .s_clk_20mhz     (s_clk_20mhz),
    .s_rst_20mhz     (s_rst_20mhz),
    .i_tx_go         (i_report_go),
    .i_dat_ascii_line(s_uart_line),
    .i_tx_ready      (s_tx_ready),
    .o_tx_data       (s_tx_data),
    .o_tx_valid      (s_tx_valid),
    .o_feed_idle     (s_feed_idle)
  );

  // 8N1 frame generation on the TX pin
  uart_tx_serializer u_uart_tx_serializer (
    .s_clk_20mhz(s_clk_20mhz),
    .s_rst_20mhz(s_rst_20mhz),
    .i_tx_data  (s_tx_data),
    .i_tx_valid (s_tx_valid),
    .o_tx_ready (s_tx_ready),
    .o_uart_tx  (o_uart_tx)
  );

endmodule : acl_report_top

//--- verilog/uart_tx_serializer.sv
`timescale 1ns/1ps
`include "acl_report_params.svh"

module uart_tx_serializer
  import acl_report_pkg::*;
(
  input  logic        s_clk_20mhz,
  input  logic        s_rst_20mhz,
  input  ascii_char_t i_tx_data,
  input  logic        i_tx_valid,
  output logic        o_tx_ready,  // High only while idle
  output logic        o_uart_tx    // Registered serial line
);

  localparam int c_bit_cnt_w = $clog2(`ACL_CLKS_PER_BIT);

  ser_state_e              s_state;
  ascii_char_t             s_data;     // Byte being framed
  logic [c_bit_cnt_w-1:0]  s_clk_cnt;  // Cycles into current bit
  logic [2:0]              s_bit_idx;  // Data bit on the line
  logic                    s_bit_end;

  assign o_tx_ready = (s_state == sr_idle);
  assign s_bit_end  = (s_clk_cnt == c_bit_cnt_w'(`ACL_CLKS_PER_BIT - 1));

  // ------------------------------------------------------------------------
  // Frame FSM
  // ------------------------------------------------------------------------

  always_ff @(posedge s_clk_20mhz) begin : p_ser_fsm
    if (s_rst_20mhz) begin
      s_state   <= sr_idle;
      s_clk_cnt <= '0;
      s_bit_idx <= '0;
      o_uart_tx <= 1'b1;  // Line idles high
    end else begin
      s_clk_cnt <= s_bit_end ? '0 : s_clk_cnt + 1'b1;
      case (s_state)
        sr_idle: begin
          s_clk_cnt <= '0;
          if (i_tx_valid) begin
            o_uart_tx <= 1'b0;  // Start bit
            s_bit_idx <= '0;
            s_state   <= sr_start;
          end
        end
        sr_start: begin
          if (s_bit_end) begin
            o_uart_tx <= s_data[0];  // LSB first
            s_state   <= sr_data;
          end
        end
        sr_data: begin
          if (s_bit_end) begin
            if (s_bit_idx == 3'd7) begin
              o_uart_tx <= 1'b1;  // Stop bit
              s_state   <= sr_stop;
            end else begin
              o_uart_tx <= s_data[s_bit_idx + 3'd1];
              s_bit_idx <= s_bit_idx + 3'd1;
            end
          end
        end
        sr_stop: begin
          if (s_bit_end) begin
            s_state <= sr_idle;  // Ready again after full stop bit
          end
        end
        default: s_state <= sr_idle;
      endcase
    end
  end : p_ser_fsm

  // Byte capture on accept
  always_ff @(posedge s_clk_20mhz) begin : p_data_reg
    if ((s_state == sr_idle) && i_tx_valid) begin
      s_data <= i_tx_data;
    end
  end : p_data_reg

endmodule : uart_tx_serializer

//--- verilog/uart_tx_feed.sv
`timescale 1ns/1ps
`include "acl_report_params.svh"

module uart_tx_feed
  import acl_report_pkg::*;
(
  input  logic        s_clk_20mhz,
  input  logic        s_rst_20mhz,
  input  logic        i_tx_go,           // Report strobe
  input  uart_line_t  i_dat_ascii_line,
  input  logic        i_tx_ready,        // Serializer idle
  output ascii_char_t o_tx_data,
  output logic        o_tx_valid,
  output logic        o_feed_idle
);

  localparam int c_cnt_w = $clog2(`ACL_UART_CHARS);

  feed_state_e         s_state;
  uart_line_t          s_line;      // Remaining characters, next one on top
  logic [c_cnt_w-1:0]  s_char_cnt;  // Characters already handed over

  // ------------------------------------------------------------------------
  // Handshake outputs
  // ------------------------------------------------------------------------

  assign o_tx_valid  = (s_state == fd_load);
  assign o_tx_data   = s_line[$bits(uart_line_t)-1 -: 8];  // Top byte
  assign o_feed_idle = (s_state == fd_idle);

  // ------------------------------------------------------------------------
  // Feed FSM
  // ------------------------------------------------------------------------

  always_ff @(posedge s_clk_20mhz) begin : p_feed_fsm
    if (s_rst_20mhz) begin
      s_state    <= fd_idle;
      s_char_cnt <= '0;
    end else begin
      case (s_state)
        fd_idle: begin
          if (i_tx_go) begin
            s_char_cnt <= '0;
            s_state    <= fd_load;  // Valid rises next cycle
          end
        end
        fd_load: begin
          if (i_tx_ready) begin
            s_state <= fd_send;  // Byte accepted this cycle
          end
        end
        fd_send: begin
          s_char_cnt <= s_char_cnt + 1'b1;
          // Valid stays low here for one cycle
          if (s_char_cnt == c_cnt_w'(`ACL_UART_CHARS - 1)) begin
            s_state <= fd_wait;
          end else begin
            s_state <= fd_load;
          end
        end
        fd_wait: begin
          if (i_tx_ready) begin
            s_state <= fd_idle;  // Last stop bit done
          end
        end
        default: s_state <= fd_idle;
      endcase
    end
  end : p_feed_fsm

  // Line shift register, loaded on the strobe
  always_ff @(posedge s_clk_20mhz) begin : p_line_shift
    if ((s_state == fd_idle) && i_tx_go) begin
      s_line <= i_dat_ascii_line;
    end else if (s_state == fd_send) begin
      s_line <= s_line << 8;  // Bring up the next character
    end
  end : p_line_shift

endmodule : uart_tx_feed

//--- verilog/adxl362_readings_to_ascii.sv
`timescale 1ns/1ps
`include "acl_report_params.svh"

module adxl362_readings_to_ascii
  import acl_report_pkg::*;
(
  input  logic       s_clk_20mhz,
  input  logic       s_rst_20mhz,
  input  acl_meas_t  i_meas,
  input  logic       i_meas_valid,
  input  logic       i_feed_idle,         // Low while a report is on the wire
  input  logic       i_reading_inactive,
  input  logic [3:0] i_btn_deb,
  output uart_line_t o_uart_line
);

  // ------------------------------------------------------------------------
  // Nibble and field conversion
  // ------------------------------------------------------------------------

  // One hex digit, uppercase
  function automatic ascii_char_t nib_to_hex(input logic [3:0] nib);
    if (nib < 4'd10) begin
      return 8'h30 + {4'h0, nib};  // '0'..'9'
    end else begin
      return 8'h37 + {4'h0, nib};  // 'A'..'F'
    end
  endfunction

  // Four digits, most significant first
  function automatic logic [31:0] axis_to_hex(input acl_axis_t axis);
    return {nib_to_hex(axis[15:12]), nib_to_hex(axis[11:8]),
            nib_to_hex(axis[7:4]), nib_to_hex(axis[3:0])};
  endfunction

  // ------------------------------------------------------------------------
  // Measurement hold
  // ------------------------------------------------------------------------

  acl_meas_t s_meas_hold;  // Frozen while the feed is busy
  acl_axis_t s_x_axis;
  acl_axis_t s_y_axis;
  acl_axis_t s_z_axis;
  acl_axis_t s_temp;

  lcd_line_t s_dat_line1;
  lcd_line_t s_dat_line2;
  lcd_line_t s_txt_line1;
  lcd_line_t s_txt_line2;

  always_ff @(posedge s_clk_20mhz) begin : p_hold_meas
    if (s_rst_20mhz) begin
      s_meas_hold <= '0;
    end else if (i_meas_valid && i_feed_idle) begin
      s_meas_hold <= i_meas;  // Only take new data between reports
    end
  end : p_hold_meas

  // Field split of the held reading
  assign s_x_axis = s_meas_hold[63:48];
  assign s_y_axis = s_meas_hold[47:32];
  assign s_z_axis = s_meas_hold[31:16];
  assign s_temp   = s_meas_hold[15:0];

  // ------------------------------------------------------------------------
  // Display lines
  // ------------------------------------------------------------------------

  // "X=hhhh  Y=hhhh  "
  assign s_dat_line1 = {"X=", axis_to_hex(s_x_axis), "  ",
                        "Y=", axis_to_hex(s_y_axis), "  "};

  // "Z=hhhh  T=hhhh  "
  assign s_dat_line2 = {"Z=", axis_to_hex(s_z_axis), "  ",
                        "T=", axis_to_hex(s_temp), "  "};

  assign s_txt_line1 = "ACL2 READINGS   ";

  // Activity state from tester flag
  assign s_txt_line2 = i_reading_inactive ? "STATE: INACTIVE "
                                          : "STATE: ACTIVE   ";

  // ------------------------------------------------------------------------
  // Terminal line register
  // ------------------------------------------------------------------------

  always_ff @(posedge s_clk_20mhz) begin : p_reg_uart_line
    if (i_btn_deb == `ACL_BTN_TEXT_SEL) begin
      o_uart_line <= {s_txt_line1, s_txt_line2, 8'h0D, 8'h0A};  // Text view
    end else begin
      o_uart_line <= {s_dat_line1, s_dat_line2, 8'h0D, 8'h0A};  // Hex data
    end
  end : p_reg_uart_line

endmodule : adxl362_readings_to_ascii

//--- verilog/acl_report_pkg.sv
`include "acl_report_params.svh"

package acl_report_pkg;

  // ------------------------------------------------------------------------
  // Data vectors
  // ------------------------------------------------------------------------

  typedef logic [63:0] acl_meas_t;  // X, Y, Z, temperature from MSB down
  typedef logic [15:0] acl_axis_t;  // One field of a reading
  typedef logic [7:0]  ascii_char_t;

  // First character sits in the top byte
  typedef logic [`ACL_LCD_CHARS*8-1:0]  lcd_line_t;
  typedef logic [`ACL_UART_CHARS*8-1:0] uart_line_t;

  // ------------------------------------------------------------------------
  // State machines
  // ------------------------------------------------------------------------

  typedef enum logic [1:0] {
    fd_idle,  // Waiting for report strobe
    fd_load,  // Byte offered to serializer
    fd_send,  // Byte taken, advance line
    fd_wait   // Last frame still on the wire
  } feed_state_e;

  typedef enum logic [1:0] {
    sr_idle,   // Line high, ready for a byte
    sr_start,  // Start bit
    sr_data,   // Eight data bits, LSB first
    sr_stop    // Stop bit
  } ser_state_e;

endpackage : acl_report_pkg

//--- include/acl_report_params.svh
`ifndef ACL_REPORT_PARAMS_SVH
`define ACL_REPORT_PARAMS_SVH

// ------------------------------------------------------------------------
// UART bit timing
// ------------------------------------------------------------------------

// 20 MHz / 115200 baud, rounded
`define ACL_CLKS_PER_BIT 174

// ------------------------------------------------------------------------
// Line lengths in characters
// ------------------------------------------------------------------------

`define ACL_LCD_CHARS 16   // One 16x2 display row
`define ACL_UART_CHARS 34  // Two display rows plus CR and LF

// ------------------------------------------------------------------------
// Button code for the terminal text view
// ------------------------------------------------------------------------

`define ACL_BTN_TEXT_SEL 4'b0100  // Button 2 pressed alone

`endif
